/* Makefile */
# Verilator build and run of the vector address generator testbench

TOP := vaddrgen_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, judge $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+include
verilog/vaddrgen_pkg.sv
verilog/vldst_req_intake.sv
verilog/axi_ax_gen.sv
verilog/ldst_cmd_queue.sv
verilog/vaddrgen_top.sv
dv/vaddrgen_assertions.sv
dv/vaddrgen_tb.sv

/* dv/vaddrgen_assertions.sv */
`timescale 1ns/1ps

module vaddrgen_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic ack_o,
  input logic error_o,
  input logic ar_valid_o,
  input logic ar_ready_i,
  input logic aw_valid_o,
  input logic aw_ready_i
);

  // One address channel per cycle
  one_channel_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o)) else $error("AR and AW valid high together");

  // Valid is a transfer strobe
  ar_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o |-> ar_ready_i) else $error("AR valid without AR ready");
  aw_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o |-> aw_ready_i) else $error("AW valid without AW ready");

  // Error only rides on an acknowledge
  error_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_o |-> ack_o) else $error("error without ack");

  // Quiet sequencer side in reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> (!ack_o && !error_o)) else $error("ack or error during reset");

endmodule

bind vaddrgen_top vaddrgen_assertions assertions_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ack_o      (ack_o),
  .error_o    (error_o),
  .ar_valid_o (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .aw_valid_o (aw_valid_o),
  .aw_ready_i (aw_ready_i)
);

/* dv/vaddrgen_tb.sv */
`timescale 1ns/1ps
`include "vaddrgen_defines.svh"

module vaddrgen_tb;

  localparam int CLK_PERIOD = 100;
  // Requests over all tests and the watchdog limit they allow
  localparam int NUM_REQS    = 236;
  localparam int WATCHDOG_NS = NUM_REQS * ((1 << `VA_VL_W) - 1 + 20) * CLK_PERIOD;

  // Expected beat with the channel it must appear on
  typedef struct packed {
    logic                  is_load;
    vaddrgen_pkg::ax_req_t ax;
  } exp_beat_t;

  logic                    clk_i;
  logic                    rst_ni;
  vaddrgen_pkg::pe_req_t   pe_req_i;
  logic                    pe_req_valid_i;
  logic                    ack_o;
  logic                    error_o;
  vaddrgen_pkg::ax_req_t   ar_o;
  logic                    ar_valid_o;
  logic                    ar_ready_i;
  vaddrgen_pkg::ax_req_t   aw_o;
  logic                    aw_valid_o;
  logic                    aw_ready_i;
  vaddrgen_pkg::ldst_cmd_t ldst_cmd_o;
  logic                    ldst_cmd_valid_o;
  logic                    ldu_ready_i;
  logic                    stu_ready_i;

  // Scoreboards filled by the model
  exp_beat_t               exp_ax[$];
  vaddrgen_pkg::ldst_cmd_t exp_cmd[$];

  int   errors        = 0;
  int   checks        = 0;
  int   tests_run     = 0;
  int   test_err_base = 0;
  int   ack_count     = 0;
  int   reqs_sent     = 0;
  int   ar_beats      = 0;
  int   aw_beats      = 0;
  // Commands the DUT queue holds right now
  int   q_occ         = 0;
  int   pop_hold      = 0;
  logic last_ack_err  = 1'b0;
  logic backpressure  = 1'b0;
  logic pop_en        = 1'b1;

  vaddrgen_top vaddrgen_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Base must be a multiple of the element bytes
  function automatic logic is_misaligned(input vaddrgen_pkg::pe_req_t r);
    return (r.addr % (`VA_ADDR_W'(1) << r.vew)) != `VA_ADDR_W'(0);
  endfunction

  task automatic build_expected(input vaddrgen_pkg::pe_req_t r);
    exp_beat_t               b;
    vaddrgen_pkg::ldst_cmd_t c;
    int unsigned             nbytes;
    logic                    is_burst;
    b.is_load = (r.op == vaddrgen_pkg::OP_VLE) || (r.op == vaddrgen_pkg::OP_VLSE);
    is_burst  = (r.op == vaddrgen_pkg::OP_VLE) || (r.op == vaddrgen_pkg::OP_VSE);
    // INCR
    b.ax.burst = 2'b01;
    if (is_burst) begin
      // Beat count is the byte length over the bus width, rounded up
      nbytes    = 32'(r.vl) << r.vew;
      b.ax.addr = r.addr;
      b.ax.len  = `VA_AXLEN_W'(((nbytes + (1 << `VA_BUS_BYTES_LOG) - 1) >> `VA_BUS_BYTES_LOG) - 1);
      b.ax.size = 3'(`VA_BUS_BYTES_LOG);
      exp_ax.push_back(b);
    end else begin
      for (int k = 0; k < int'(r.vl); k++) begin
        b.ax.addr = r.addr + `VA_ADDR_W'(k) * r.stride;
        b.ax.len  = '0;
        b.ax.size = {1'b0, r.vew};
        exp_ax.push_back(b);
      end
    end
    // One command per beat with the same fields
    foreach (exp_ax[i]) begin
      if (i >= exp_ax.size() - (is_burst ? 1 : int'(r.vl))) begin
        c.addr    = exp_ax[i].ax.addr;
        c.len     = exp_ax[i].ax.len;
        c.size    = exp_ax[i].ax.size;
        c.is_load = exp_ax[i].is_load;
        exp_cmd.push_back(c);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampling 10 ns ahead of each rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic observe_beat();
    exp_beat_t got;
    got.is_load = ar_valid_o;
    got.ax      = ar_valid_o ? ar_o : aw_o;
    check_eq(64'(got.is_load ? ar_ready_i : aw_ready_i), 64'd1, "AX valid without ready");
    check_eq(64'(q_occ < `VA_QUEUE_DEPTH), 64'd1, "AX beat while the queue is full");
    if (q_occ != 0) begin
      check_eq(64'(exp_cmd[0].is_load), 64'(got.is_load), "beat against the queued direction");
    end
    check_eq(64'(exp_ax.size() != 0), 64'd1, "AX beat with none expected");
    if (exp_ax.size() != 0) begin
      check_eq(64'(got), 64'(exp_ax.pop_front()), "AX beat");
    end
    if (got.is_load) begin
      ar_beats++;
    end else begin
      aw_beats++;
    end
  endtask

  task automatic observe_pop();
    check_eq(64'(exp_cmd.size() != 0), 64'd1, "command popped with none expected");
    if (exp_cmd.size() != 0) begin
      check_eq(64'(ldst_cmd_o), 64'(exp_cmd.pop_front()), "queue command");
    end
  endtask

  task automatic sample_outputs();
    logic beat;
    logic pop;
    beat = ar_valid_o || aw_valid_o;
    pop  = ldst_cmd_valid_o && (ldu_ready_i || stu_ready_i);
    if (ack_o) begin
      ack_count++;
      last_ack_err = error_o;
    end
    check_eq(64'(ar_valid_o && aw_valid_o), 64'd0, "AR and AW valid together");
    check_eq(64'(ldst_cmd_valid_o), 64'(q_occ != 0), "command valid against occupancy");
    if (beat) begin
      observe_beat();
    end
    if (pop) begin
      observe_pop();
    end
    // A good request is acknowledged together with its last beat
    if (ack_o && !error_o) begin
      check_eq(64'(beat), 64'd1, "ack without a beat");
      check_eq(64'(exp_ax.size()), 64'd0, "ack before the last beat");
    end
    q_occ = q_occ + int'(beat) - int'(pop);
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      #(CLK_PERIOD / 2 - 10);
      if (rst_ni) begin
        sample_outputs();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Random AX readies and pops with pops held off for stretches
  task automatic drive_readies();
    ar_ready_i = !backpressure || ($urandom_range(3) != 0);
    aw_ready_i = !backpressure || ($urandom_range(3) != 0);
    if (pop_hold > 0) begin
      pop_hold--;
    end else if (backpressure && $urandom_range(15) == 0) begin
      pop_hold = int'($urandom_range(8, 1));
    end
    ldu_ready_i = pop_en && (pop_hold == 0) && (!backpressure || $urandom_range(1) == 1);
    stu_ready_i = pop_en && (pop_hold == 0) && (!backpressure || $urandom_range(1) == 1);
  endtask

  initial begin
    ar_ready_i  = 1'b1;
    aw_ready_i  = 1'b1;
    ldu_ready_i = 1'b1;
    stu_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      drive_readies();
    end
  end

  // op above 3 picks any opcode; align 0 aligned, 1 misaligned, 2 random
  function automatic vaddrgen_pkg::pe_req_t rand_req(input int unsigned op,
                                                     input int unsigned align);
    vaddrgen_pkg::pe_req_t r;
    logic [`VA_ADDR_W-1:0] ebytes;
    r.op     = vaddrgen_pkg::mem_op_e'(2'(op > 3 ? $urandom_range(3) : op));
    r.vl     = `VA_VL_W'($urandom_range((1 << `VA_VL_W) - 1, 1));
    r.stride = $urandom;
    r.addr   = $urandom;
    // Byte elements cannot be misaligned
    r.vew    = vaddrgen_pkg::vew_e'(2'($urandom_range(3, align == 1 ? 1 : 0)));
    ebytes   = `VA_ADDR_W'(1) << r.vew;
    if (align == 0) begin
      r.addr = r.addr - (r.addr % ebytes);
    end else if (align == 1) begin
      r.addr[0] = 1'b1;
    end
    return r;
  endfunction

  // Called on a falling edge and holds the request until ack
  task automatic send_req(input vaddrgen_pkg::pe_req_t r);
    int   acks_before;
    int   waited;
    logic exp_err;
    reqs_sent++;
    exp_err = is_misaligned(r);
    if (!exp_err) begin
      build_expected(r);
    end
    acks_before    = ack_count;
    pe_req_i       = r;
    pe_req_valid_i = 1'b1;
    waited         = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (ack_count == acks_before);
    pe_req_valid_i = 1'b0;
    check_eq(64'(last_ack_err), 64'(exp_err), "error flag on ack");
    if (exp_err) begin
      // Capture edge then the single CHECK cycle
      check_eq(64'(waited), 64'd2, "cycles to the error ack");
    end
  endtask

  task automatic wait_drain();
    pop_en = 1'b1;
    while (exp_ax.size() != 0 || exp_cmd.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    check_eq(64'(q_occ), 64'd0, "queue occupancy after drain");
  endtask

  task automatic end_test(input string name);
    wait_drain();
    check_eq(64'(ack_count), 64'(reqs_sent), "acks against requests sent");
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // Second request must wait until the first one's commands are popped
  task automatic run_ordering(input int unsigned first_op, input int unsigned second_op);
    vaddrgen_pkg::pe_req_t first;
    vaddrgen_pkg::pe_req_t second;
    int                    beats_before;
    first    = rand_req(first_op, 0);
    first.vl = `VA_VL_W'(3);
    second   = rand_req(second_op, 0);
    pop_en   = 1'b0;
    send_req(first);
    beats_before = ar_beats + aw_beats;
    fork
      send_req(second);
      begin
        repeat (20) @(negedge clk_i);
        check_eq(64'(ar_beats + aw_beats), 64'(beats_before), "beat before the queue drained");
        pop_en = 1'b1;
      end
    join
  endtask

  initial begin
    void'($urandom(1));
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_eq(64'({ack_o, error_o, ar_valid_o, aw_valid_o, ldst_cmd_valid_o}), 64'd0,
             "outputs after reset");

    for (int i = 0; i < 4; i++) begin
      send_req(rand_req(i % 2, 0));
    end
    end_test("unit-stride");
    for (int i = 0; i < 4; i++) begin
      send_req(rand_req(2 + i % 2, 0));
    end
    end_test("strided");
    for (int i = 0; i < 4; i++) begin
      send_req(rand_req(i, 1));
    end
    end_test("misaligned");

    backpressure = 1'b1;
    for (int i = 0; i < 20; i++) begin
      send_req(rand_req(4, 0));
    end
    end_test("back-pressure");
    backpressure = 1'b0;

    // Loads then a store, stores then a load
    run_ordering(vaddrgen_pkg::OP_VLSE, vaddrgen_pkg::OP_VSE);
    run_ordering(vaddrgen_pkg::OP_VSSE, vaddrgen_pkg::OP_VLE);
    end_test("ordering");

    for (int i = 0; i < 200; i++) begin
      backpressure = 1'($urandom_range(1));
      send_req(rand_req(4, 2));
    end
    backpressure = 1'b0;
    end_test("random mix");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

/* include/vaddrgen_defines.svh */
`ifndef VADDRGEN_DEFINES_SVH
`define VADDRGEN_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Byte address width on the AXI address channels
`define VA_ADDR_W 32

// Vector length width, vl is at most 255
`define VA_VL_W 8

// AXI len field width
`define VA_AXLEN_W 8

////////////////////////////////////////////////////////////////////////////
// Bus and queue sizing
////////////////////////////////////////////////////////////////////////////

// Log2 of the AXI data bytes per beat (64-bit bus)
`define VA_BUS_BYTES_LOG 3

// Entries in the load/store command queue
`define VA_QUEUE_DEPTH 4

`endif

/* verilog/axi_ax_gen.sv */
`timescale 1ns/1ps
`include "vaddrgen_defines.svh"

module axi_ax_gen (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Checked request from the intake
  input  vaddrgen_pkg::addrgen_req_t req_i,
  input  logic                       req_valid_i,
  output logic                       req_done_o,
  // AXI read address channel
  output vaddrgen_pkg::ax_req_t      ar_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  // AXI write address channel
  output vaddrgen_pkg::ax_req_t      aw_o,
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  // Command queue
  output vaddrgen_pkg::ldst_cmd_t    cmd_o,
  output logic                       cmd_push_o,
  input  logic                       q_full_i,
  input  logic                       q_empty_i,
  input  logic                       q_head_is_load_i
);

  vaddrgen_pkg::axgen_state_e state_q;
  vaddrgen_pkg::axgen_state_e state_d;

  // Working copy of the request
  vaddrgen_pkg::addrgen_req_t work_q;
  logic [`VA_AXLEN_W-1:0]     burst_len_q;

  logic [`VA_VL_W+2:0]        byte_len;
  logic [`VA_VL_W+2:0]        beats_m1;
  logic                       capture;
  logic                       order_ok;
  logic                       ax_ready;
  logic                       fire;
  logic                       last_beat;
  vaddrgen_pkg::ax_req_t      beat;

  ////////////////////////////////////////////////////////////////////////////
  // Burst sizing
  ////////////////////////////////////////////////////////////////////////////

  // Bytes of the whole unit-stride access
  assign byte_len = {3'b000, req_i.len} << req_i.vew;

  // Beat count minus one, rounded up to whole bus words
  assign beats_m1 = (byte_len - 1'b1) >> `VA_BUS_BYTES_LOG;

  assign capture = (state_q == vaddrgen_pkg::AX_IDLE) && req_valid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Issue gating
  ////////////////////////////////////////////////////////////////////////////

  // No channel switch while the other channel still has queued commands
  assign order_ok = q_empty_i || (q_head_is_load_i == work_q.is_load);

  assign ax_ready = work_q.is_load ? ar_ready_i : aw_ready_i;

  // A raised valid is a completed transfer
  assign fire = (state_q == vaddrgen_pkg::AX_REQUESTING) && order_ok && !q_full_i && ax_ready;

  // Bursts are a single request, strided ones end on the final element
  assign last_beat = work_q.is_burst || (work_q.len <= `VA_VL_W'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Beat and command
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    beat.addr  = work_q.addr;
    beat.burst = vaddrgen_pkg::AX_BURST_INCR;
    if (work_q.is_burst) begin
      beat.len  = burst_len_q;
      beat.size = 3'(`VA_BUS_BYTES_LOG);
    end else begin
      // Single element per strided beat
      beat.len  = '0;
      beat.size = {1'b0, work_q.vew};
    end
  end

  assign ar_o       = beat;
  assign aw_o       = beat;
  assign ar_valid_o = fire && work_q.is_load;
  assign aw_valid_o = fire && !work_q.is_load;

  // Same content as the AX beat plus the direction
  assign cmd_o.addr    = beat.addr;
  assign cmd_o.len     = beat.len;
  assign cmd_o.size    = beat.size;
  assign cmd_o.is_load = work_q.is_load;
  assign cmd_push_o    = fire;

  assign req_done_o = fire && last_beat;

  ////////////////////////////////////////////////////////////////////////////
  // FSM and working registers
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vaddrgen_pkg::AX_IDLE: begin
        if (req_valid_i) begin
          state_d = vaddrgen_pkg::AX_REQUESTING;
        end
      end
      vaddrgen_pkg::AX_REQUESTING: begin
        if (req_done_o) begin
          state_d = vaddrgen_pkg::AX_IDLE;
        end
      end
      default: state_d = vaddrgen_pkg::AX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vaddrgen_pkg::AX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      work_q      <= req_i;
      burst_len_q <= beats_m1[`VA_AXLEN_W-1:0];
    end else if (fire && !work_q.is_burst) begin
      // Next strided element
      work_q.len  <= work_q.len - 1'b1;
      work_q.addr <= work_q.addr + work_q.stride;
    end
  end

endmodule

/* verilog/ldst_cmd_queue.sv */
`timescale 1ns/1ps
`include "vaddrgen_defines.svh"

module ldst_cmd_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Push side, from the generator
  input  vaddrgen_pkg::ldst_cmd_t cmd_i,
  input  logic                    push_i,
  // Pop side, load and store units
  input  logic                    ldu_ready_i,
  input  logic                    stu_ready_i,
  output vaddrgen_pkg::ldst_cmd_t cmd_o,
  output logic                    valid_o,
  // Status
  output logic                    full_o,
  output logic                    empty_o,
  output logic                    head_is_load_o
);

  localparam int unsigned PtrW = $clog2(`VA_QUEUE_DEPTH);
  localparam int unsigned CntW = $clog2(`VA_QUEUE_DEPTH + 1);

  vaddrgen_pkg::ldst_cmd_t mem_q [`VA_QUEUE_DEPTH];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign full_o  = (count_q == CntW'(`VA_QUEUE_DEPTH));
  assign empty_o = (count_q == '0);

  // Either unit takes the head, nothing to take when empty
  assign pop  = (ldu_ready_i || stu_ready_i) && !empty_o;
  assign push = push_i && !full_o;

  assign cmd_o          = mem_q[rd_ptr_q];
  assign valid_o        = !empty_o;
  assign head_is_load_o = mem_q[rd_ptr_q].is_load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`VA_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`VA_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

endmodule

/* verilog/vaddrgen_pkg.sv */
`include "vaddrgen_defines.svh"

package vaddrgen_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Element width, encoded as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector memory opcodes
  typedef enum logic [1:0] {
    OP_VLE  = 2'd0,
    OP_VSE  = 2'd1,
    OP_VLSE = 2'd2,
    OP_VSSE = 2'd3
  } mem_op_e;

  // AXI burst type code for incrementing bursts
  localparam logic [1:0] AX_BURST_INCR = 2'b01;

  ////////////////////////////////////////////////////////////////////////////
  // Interface structs
  ////////////////////////////////////////////////////////////////////////////

  // Request from the sequencer
  typedef struct packed {
    mem_op_e                op;
    logic [`VA_ADDR_W-1:0]  addr;
    logic [`VA_VL_W-1:0]    vl;
    logic [`VA_ADDR_W-1:0]  stride;
    vew_e                   vew;
  } pe_req_t;

  // Checked request, intake to generator
  typedef struct packed {
    logic [`VA_ADDR_W-1:0]  addr;
    // Remaining elements
    logic [`VA_VL_W-1:0]    len;
    logic [`VA_ADDR_W-1:0]  stride;
    vew_e                   vew;
    logic                   is_load;
    // Unit-stride, one INCR burst
    logic                   is_burst;
  } addrgen_req_t;

  // One beat on AR or AW
  typedef struct packed {
    logic [`VA_ADDR_W-1:0]  addr;
    logic [`VA_AXLEN_W-1:0] len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } ax_req_t;

  // Command for the load/store units
  typedef struct packed {
    logic [`VA_ADDR_W-1:0]  addr;
    logic [`VA_AXLEN_W-1:0] len;
    logic [2:0]             size;
    logic                   is_load;
  } ldst_cmd_t;

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    WAIT_DONE
  } intake_state_e;

  typedef enum logic {
    AX_IDLE,
    AX_REQUESTING
  } axgen_state_e;

endpackage

/* verilog/vaddrgen_top.sv */
`timescale 1ns/1ps

module vaddrgen_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Sequencer
  input  vaddrgen_pkg::pe_req_t   pe_req_i,
  input  logic                    pe_req_valid_i,
  output logic                    ack_o,
  output logic                    error_o,
  // AXI address channels
  output vaddrgen_pkg::ax_req_t   ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output vaddrgen_pkg::ax_req_t   aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  // Load/store units
  output vaddrgen_pkg::ldst_cmd_t ldst_cmd_o,
  output logic                    ldst_cmd_valid_o,
  input  logic                    ldu_ready_i,
  input  logic                    stu_ready_i
);

  // Intake to generator
  vaddrgen_pkg::addrgen_req_t addrgen_req;
  logic                       addrgen_req_valid;
  logic                       addrgen_req_done;

  // Generator to queue
  vaddrgen_pkg::ldst_cmd_t    cmd;
  logic                       cmd_push;
  logic                       q_full;
  logic                       q_empty;
  logic                       q_head_is_load;

  vldst_req_intake intake_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .req_o          (addrgen_req),
    .req_valid_o    (addrgen_req_valid),
    .req_done_i     (addrgen_req_done),
    .ack_o          (ack_o),
    .error_o        (error_o)
  );

  axi_ax_gen ax_gen_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (addrgen_req),
    .req_valid_i      (addrgen_req_valid),
    .req_done_o       (addrgen_req_done),
    .ar_o             (ar_o),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .aw_o             (aw_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .cmd_o            (cmd),
    .cmd_push_o       (cmd_push),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (q_head_is_load)
  );

  ldst_cmd_queue cmd_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .push_i         (cmd_push),
    .ldu_ready_i    (ldu_ready_i),
    .stu_ready_i    (stu_ready_i),
    .cmd_o          (ldst_cmd_o),
    .valid_o        (ldst_cmd_valid_o),
    .full_o         (q_full),
    .empty_o        (q_empty),
    .head_is_load_o (q_head_is_load)
  );

endmodule

/* verilog/vldst_req_intake.sv */
`timescale 1ns/1ps
`include "vaddrgen_defines.svh"

module vldst_req_intake (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Sequencer side
  input  vaddrgen_pkg::pe_req_t      pe_req_i,
  input  logic                       pe_req_valid_i,
  // Generator side
  output vaddrgen_pkg::addrgen_req_t req_o,
  output logic                       req_valid_o,
  input  logic                       req_done_i,
  // Acknowledge pulses
  output logic                       ack_o,
  output logic                       error_o
);

  vaddrgen_pkg::intake_state_e state_q;
  vaddrgen_pkg::intake_state_e state_d;

  // Held copy of the sequencer request
  vaddrgen_pkg::pe_req_t req_q;

  logic [`VA_ADDR_W-1:0] align_mask;
  logic                  misaligned;

  // Low vew bits of the base must be zero
  assign align_mask = (`VA_ADDR_W'(1) << req_q.vew) - `VA_ADDR_W'(1);
  assign misaligned = |(req_q.addr & align_mask);

  // Checked request toward the generator
  assign req_o.addr     = req_q.addr;
  assign req_o.len      = req_q.vl;
  assign req_o.stride   = req_q.stride;
  assign req_o.vew      = req_q.vew;
  assign req_o.is_load  = req_q.op inside {vaddrgen_pkg::OP_VLE, vaddrgen_pkg::OP_VLSE};
  assign req_o.is_burst = req_q.op inside {vaddrgen_pkg::OP_VLE, vaddrgen_pkg::OP_VSE};

  always_comb begin
    state_d     = state_q;
    req_valid_o = 1'b0;
    ack_o       = 1'b0;
    error_o     = 1'b0;

    case (state_q)
      vaddrgen_pkg::IDLE: begin
        // Capture happens in the register block below
        if (pe_req_valid_i) begin
          state_d = vaddrgen_pkg::CHECK;
        end
      end
      vaddrgen_pkg::CHECK: begin
        // One cycle only, misaligned requests end here
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = vaddrgen_pkg::IDLE;
        end else begin
          state_d = vaddrgen_pkg::WAIT_DONE;
        end
      end
      vaddrgen_pkg::WAIT_DONE: begin
        // Level until the generator issues the last beat
        req_valid_o = 1'b1;
        if (req_done_i) begin
          ack_o   = 1'b1;
          state_d = vaddrgen_pkg::IDLE;
        end
      end
      default: state_d = vaddrgen_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vaddrgen_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, loaded only in IDLE
  always_ff @(posedge clk_i) begin
    if (state_q == vaddrgen_pkg::IDLE && pe_req_valid_i) begin
      req_q <= pe_req_i;
    end
  end

endmodule
